/* verilog/alu_cfg_pkg.sv */
package alu_cfg_pkg;

   // operand width used by the top level unless overridden
   parameter int XLEN_DEFAULT = 32;

   // bits needed to count 0 .. xlen-1, never less than one
   function automatic int cnt_width(input int xlen);
      int w;
      w = $clog2(xlen);
      if (w < 1) begin
         w = 1;
      end
      return w;
   endfunction

endpackage

/* verilog/alu_op_pkg.sv */
package alu_op_pkg;

   // alu operation, selects what ends up in the result word
   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_SLT  = 3'd2,
      ALU_SLTU = 3'd3,
      ALU_XOR  = 3'd4,
      ALU_OR   = 3'd5,
      ALU_AND  = 3'd6
   } alu_op_t;

   // branch style compare, selects the compare flag
   typedef enum logic [2:0] {
      CMP_EQ  = 3'd0,
      CMP_NE  = 3'd1,
      CMP_LT  = 3'd2,
      CMP_GE  = 3'd3,
      CMP_LTU = 3'd4,
      CMP_GEU = 3'd5
   } cmp_mode_t;

endpackage

/* verilog/operand_serializer.sv */
module operand_serializer
   import alu_cfg_pkg::*;
   import alu_op_pkg::*;
#(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_start,
   input  logic [XLEN-1:0] i_rs1,
   input  logic [XLEN-1:0] i_op_b,
   input  alu_op_t         i_op,
   input  cmp_mode_t       i_cmp_mode,
   output logic            o_busy,
   output logic            o_rs1_bit,
   output logic            o_op_b_bit,
   output logic            o_en,
   output logic            o_first,
   output logic            o_last,
   output alu_op_t         o_op,
   output cmp_mode_t       o_cmp_mode
);

   localparam int CW = cnt_width(XLEN);

   logic            busy_r;
   logic [CW-1:0]   cnt_r;
   logic [XLEN-1:0] rs1_sr;
   logic [XLEN-1:0] op_b_sr;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         busy_r <= 1'b0;
         cnt_r  <= '0;
      end else if (busy_r) begin
         cnt_r <= cnt_r + CW'(1);
         if (o_last) busy_r <= 1'b0;  // bit xlen-1 going out
      end else if (i_start) begin
         busy_r <= 1'b1;
         cnt_r  <= '0;
      end
   end

   // operand shift registers and op fields, loaded once per operation
   always_ff @(posedge clk) begin
      if (!busy_r && i_start) begin
         rs1_sr     <= i_rs1;
         op_b_sr    <= i_op_b;
         o_op       <= i_op;
         o_cmp_mode <= i_cmp_mode;
      end else if (busy_r) begin
         rs1_sr  <= rs1_sr >> 1;  // lsb first
         op_b_sr <= op_b_sr >> 1;
      end
   end

   assign o_busy     = busy_r;
   assign o_en       = busy_r;
   assign o_rs1_bit  = rs1_sr[0];
   assign o_op_b_bit = op_b_sr[0];
   assign o_first    = busy_r && (cnt_r == '0);
   assign o_last     = busy_r && (cnt_r == CW'(XLEN - 1));

   a_first_last : assert property (@(posedge clk) disable iff (!i_rst_n)
      !(o_first && o_last) || (XLEN == 1));

   a_start_busy : assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_start && busy_r))
      else $warning("protocol error: start while busy, ignored");

endmodule

/* verilog/serial_adder.sv */
module serial_adder (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_en,
   input  logic i_a,
   input  logic i_b,
   input  logic i_cin_first,
   input  logic i_first,
   output logic o_sum
);

   logic carry_r;
   logic cin;
   logic cout;

   // bit 0 takes the preset, later bits the stored carry
   assign cin   = i_first ? i_cin_first : carry_r;
   assign o_sum = i_a ^ i_b ^ cin;
   assign cout  = (i_a & i_b) | (cin & (i_a ^ i_b));

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry_r <= 1'b0;
      end else if (i_en) begin
         carry_r <= cout;
      end
   end

endmodule

/* verilog/serial_alu.sv */
module serial_alu
   import alu_op_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst_n,
   input  logic      i_en,
   input  logic      i_first,
   input  logic      i_last,
   input  logic      i_rs1_bit,
   input  logic      i_op_b_bit,
   input  alu_op_t   i_op,
   input  cmp_mode_t i_cmp_mode,
   output logic      o_rd_bit,
   output logic      o_en,
   output logic      o_last,
   output logic      o_cmp,
   output logic      o_lsb_from_cmp
);

   logic is_sub;
   logic is_slt_op;
   logic add_b;
   logic sum;
   logic diff;
   logic ne_r;
   logic lt_r;
   logic ne_prev;
   logic lt_prev;
   logic ne_cur;
   logic lt_u;
   logic lt_s;
   logic flag;

   assign is_sub    = (i_op == ALU_SUB);
   assign is_slt_op = (i_op == ALU_SLT) || (i_op == ALU_SLTU);
   assign add_b     = i_op_b_bit ^ is_sub;  // rs1 + ~b + 1

   serial_adder adder (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_en       (i_en),
      .i_a        (i_rs1_bit),
      .i_b        (add_b),
      .i_cin_first(is_sub),
      .i_first    (i_first),
      .o_sum      (sum)
   );

   assign diff    = i_rs1_bit ^ i_op_b_bit;
   assign ne_prev = i_first ? 1'b0 : ne_r;
   assign lt_prev = i_first ? 1'b0 : lt_r;
   assign ne_cur  = ne_prev | diff;

   // higher differing bit overrides the lower ones
   assign lt_u = diff ? (~i_rs1_bit & i_op_b_bit) : lt_prev;
   // on the sign bit the negative operand is the smaller one
   assign lt_s = diff ? (i_rs1_bit & ~i_op_b_bit) : lt_prev;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         ne_r <= 1'b0;
         lt_r <= 1'b0;
      end else if (i_en) begin
         ne_r <= ne_cur;
         lt_r <= lt_u;
      end
   end

   always_comb begin
      if (i_op == ALU_SLT) begin
         flag = lt_s;
      end else if (i_op == ALU_SLTU) begin
         flag = lt_u;
      end else begin
         case (i_cmp_mode)
            CMP_EQ:  flag = ~ne_cur;
            CMP_NE:  flag = ne_cur;
            CMP_LT:  flag = lt_s;
            CMP_GE:  flag = ~lt_s;
            CMP_LTU: flag = lt_u;
            CMP_GEU: flag = ~lt_u;
            default: flag = 1'b0;
         endcase
      end
   end

   always_comb begin
      case (i_op)
         ALU_ADD, ALU_SUB: o_rd_bit = sum;
         ALU_XOR:          o_rd_bit = diff;
         ALU_OR:           o_rd_bit = i_rs1_bit | i_op_b_bit;
         ALU_AND:          o_rd_bit = i_rs1_bit & i_op_b_bit;
         default:          o_rd_bit = 1'b0;  // slt/sltu, patched later
      endcase
   end

   assign o_cmp          = flag;  // meaningful on the last bit only
   assign o_en           = i_en;
   assign o_last         = i_en & i_last;
   assign o_lsb_from_cmp = i_en & i_last & is_slt_op;

   a_op_legal : assert property (@(posedge clk) disable iff (!i_rst_n)
      i_en |-> i_op inside {ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
                            ALU_XOR, ALU_OR, ALU_AND});

endmodule

/* verilog/result_deserializer.sv */
module result_deserializer #(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_en,
   input  logic            i_last,
   input  logic            i_rd_bit,
   input  logic            i_cmp,
   input  logic            i_lsb_from_cmp,
   output logic            o_done,
   output logic [XLEN-1:0] o_result,
   output logic            o_cmp
);

   logic [XLEN-1:0] collect_r;
   logic [XLEN-1:0] word;

   // new bit enters at the top, after xlen bits the lsb sits at bit 0
   assign word = {i_rd_bit, collect_r[XLEN-1:1]};

   always_ff @(posedge clk) begin
      if (i_en) begin
         collect_r <= word;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_done   <= 1'b0;
         o_result <= '0;
         o_cmp    <= 1'b0;
      end else begin
         o_done <= i_en & i_last;
         if (i_en && i_last) begin
            if (i_lsb_from_cmp) begin
               o_result <= XLEN'(i_cmp);  // set-less-than gives 0 or 1
            end else begin
               o_result <= word;
            end
            o_cmp <= i_cmp;
         end
      end
   end

   a_done_pulse : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_done |=> !o_done);

endmodule

/* verilog/serial_alu_top.sv */
module serial_alu_top
   import alu_cfg_pkg::*;
   import alu_op_pkg::*;
#(
   parameter int XLEN = XLEN_DEFAULT
) (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_start,
   input  logic [XLEN-1:0] i_rs1,
   input  logic [XLEN-1:0] i_op_b,
   input  alu_op_t         i_op,
   input  cmp_mode_t       i_cmp_mode,
   output logic            o_busy,
   output logic            o_done,
   output logic [XLEN-1:0] o_result,
   output logic            o_cmp
);

   // serializer to alu
   logic      s_rs1_bit;
   logic      s_op_b_bit;
   logic      s_en;
   logic      s_first;
   logic      s_last;
   alu_op_t   s_op;
   cmp_mode_t s_cmp_mode;

   // alu to deserializer
   logic      a_rd_bit;
   logic      a_en;
   logic      a_last;
   logic      a_cmp;
   logic      a_lsb_from_cmp;

   operand_serializer #(.XLEN(XLEN)) u_ser (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_start   (i_start),
      .i_rs1     (i_rs1),
      .i_op_b    (i_op_b),
      .i_op      (i_op),
      .i_cmp_mode(i_cmp_mode),
      .o_busy    (o_busy),
      .o_rs1_bit (s_rs1_bit),
      .o_op_b_bit(s_op_b_bit),
      .o_en      (s_en),
      .o_first   (s_first),
      .o_last    (s_last),
      .o_op      (s_op),
      .o_cmp_mode(s_cmp_mode)
   );

   serial_alu u_alu (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_en          (s_en),
      .i_first       (s_first),
      .i_last        (s_last),
      .i_rs1_bit     (s_rs1_bit),
      .i_op_b_bit    (s_op_b_bit),
      .i_op          (s_op),
      .i_cmp_mode    (s_cmp_mode),
      .o_rd_bit      (a_rd_bit),
      .o_en          (a_en),
      .o_last        (a_last),
      .o_cmp         (a_cmp),
      .o_lsb_from_cmp(a_lsb_from_cmp)
   );

   result_deserializer #(.XLEN(XLEN)) u_des (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_en          (a_en),
      .i_last        (a_last),
      .i_rd_bit      (a_rd_bit),
      .i_cmp         (a_cmp),
      .i_lsb_from_cmp(a_lsb_from_cmp),
      .o_done        (o_done),
      .o_result      (o_result),
      .o_cmp         (o_cmp)
   );

endmodule

/* verif/clk_gen.sv */
module clk_gen #(
   parameter int PERIOD = 4
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD / 2) o_clk = ~o_clk;
   end

endmodule

/* verif/tb_serial_alu_top.sv */
module tb_serial_alu_top
   import alu_op_pkg::*;
();

   localparam int XLEN = 32;
   localparam int TIMEOUT = 100;
   localparam logic [XLEN-1:0] MSB = XLEN'(1) << (XLEN - 1);

   logic            clk;
   logic            rst_n;
   logic            start;
   logic [XLEN-1:0] rs1;
   logic [XLEN-1:0] op_b;
   alu_op_t         op;
   cmp_mode_t       cmp_mode;
   logic            busy;
   logic            done;
   logic [XLEN-1:0] result;
   logic            cmp_out;

   logic [31:0]     rng_state;
   int              errors;
   int              checks;
   int              tests;
   int              base_errors;  // error count when the current test began
   logic [XLEN-1:0] got_result;
   logic            got_cmp;
   int              done_cycle;
   int              busy_bad;

   clk_gen #(.PERIOD(4)) u_clk (.o_clk(clk));

   serial_alu_top #(.XLEN(XLEN)) uut (
      .clk       (clk),
      .i_rst_n   (rst_n),
      .i_start   (start),
      .i_rs1     (rs1),
      .i_op_b    (op_b),
      .i_op      (op),
      .i_cmp_mode(cmp_mode),
      .o_busy    (busy),
      .o_done    (done),
      .o_result  (result),
      .o_cmp     (cmp_out)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [XLEN-1:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state[XLEN-1:0];
   endfunction

   function automatic logic [XLEN-1:0] expected_result(input alu_op_t o,
         input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      logic [XLEN-1:0] r;
      case (o)
         ALU_ADD:  r = a + b;
         ALU_SUB:  r = a - b;  // wraps modulo 2**xlen
         ALU_SLT:  r = XLEN'($signed(a) < $signed(b));
         ALU_SLTU: r = XLEN'(a < b);
         ALU_XOR:  r = a ^ b;
         ALU_OR:   r = a | b;
         ALU_AND:  r = a & b;
         default:  r = '0;
      endcase
      return r;
   endfunction

   function automatic logic expected_cmp(input alu_op_t o, input cmp_mode_t m,
         input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      logic lt_s;
      logic lt_u;
      logic f;
      lt_s = $signed(a) < $signed(b);
      lt_u = a < b;
      if (o == ALU_SLT) begin
         f = lt_s;  // the op picks the ordering, not the mode
      end else if (o == ALU_SLTU) begin
         f = lt_u;
      end else begin
         case (m)
            CMP_EQ:  f = (a == b);
            CMP_NE:  f = (a != b);
            CMP_LT:  f = lt_s;
            CMP_GE:  f = !lt_s;
            CMP_LTU: f = lt_u;
            CMP_GEU: f = !lt_u;
            default: f = 1'b0;
         endcase
      end
      return f;
   endfunction

   task automatic check_val(input string what, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic report_test(input string name);
      tests++;
      $display("test %s finished with %0d errors", name, errors - base_errors);
      base_errors = errors;
   endtask

   // restart_at > 0 gives a second start pulse on that cycle
   task automatic run_op(input alu_op_t o, input cmp_mode_t m, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input int restart_at);
      int c;
      rs1 = a;
      op_b = b;
      op = o;
      cmp_mode = m;
      start = 1'b1;
      tick();  // this edge samples start
      start = 1'b0;
      c = 1;
      busy_bad = 0;
      done_cycle = 0;
      while (!done && c <= TIMEOUT) begin
         if (busy !== 1'b1) busy_bad++;
         start = (c == restart_at);
         if (start) begin
            rs1 = ~a;  // must not reach the running operation
            op_b = ~b;
            op = ALU_AND;
         end
         tick();
         c++;
      end
      start = 1'b0;
      if (done) begin
         done_cycle = c;
         if (busy !== 1'b0) busy_bad++;
         got_result = result;
         got_cmp = cmp_out;
      end else begin
         errors++;
         $display("timeout: o_done did not rise within %0d cycles", TIMEOUT);
      end
   endtask

   task automatic run_and_check(input alu_op_t o, input cmp_mode_t m,
                                input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      run_op(o, m, a, b, 0);
      check_val($sformatf("%s result", o.name()), got_result, expected_result(o, a, b));
      check_val($sformatf("%s %s flag", o.name(), m.name()), XLEN'(got_cmp),
                XLEN'(expected_cmp(o, m, a, b)));
   endtask

   task automatic check_add_sub(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      run_and_check(ALU_ADD, CMP_EQ, a, b);
      run_and_check(ALU_SUB, CMP_NE, a, b);
   endtask

   task automatic check_all_modes(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      for (int m = 0; m < 6; m++) begin
         run_and_check(ALU_ADD, cmp_mode_t'(m), a, b);
      end
   endtask

   task automatic check_slt_pair(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      run_and_check(ALU_SLT, CMP_EQ, a, b);
      run_and_check(ALU_SLTU, CMP_EQ, a, b);
   endtask

   task automatic test_add_sub();
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      check_add_sub('0, '0);
      check_add_sub('1, XLEN'(1));  // carry runs through every bit
      check_add_sub('1, '1);
      check_add_sub('0, XLEN'(1));  // borrow through every bit
      for (int i = 0; i < 8; i++) begin
         a = next_rand();
         b = next_rand();
         check_add_sub(a, b);
      end
      report_test("add_sub");
   endtask

   task automatic test_logic();
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      for (int i = 0; i < 8; i++) begin
         a = next_rand();
         b = next_rand();
         run_and_check(ALU_XOR, CMP_EQ, a, b);
         run_and_check(ALU_OR, CMP_EQ, a, b);
         run_and_check(ALU_AND, CMP_EQ, a, b);
      end
      report_test("logic");
   endtask

   task automatic test_compare();
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      for (int i = 0; i < 4; i++) begin
         a = next_rand();
         b = next_rand();
         check_all_modes(a, b);
         check_all_modes(a, a);
         check_all_modes(a, a ^ MSB);  // only the sign bit differs
      end
      report_test("compare");
   endtask

   task automatic test_slt();
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      check_slt_pair('0, '1);
      check_slt_pair(MSB, '0);
      for (int i = 0; i < 4; i++) begin
         a = next_rand();
         b = next_rand();
         check_slt_pair(a, b);
         check_slt_pair(a, a);
         check_slt_pair(a ^ MSB, a);
      end
      report_test("slt");
   endtask

   task automatic test_timing();
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      a = next_rand();
      b = next_rand();
      run_op(ALU_SUB, CMP_LTU, a, b, 10);
      check_val("done cycle", XLEN'(done_cycle), XLEN'(XLEN + 1));
      check_val("cycles with wrong busy", XLEN'(busy_bad), '0);
      check_val("result after second start", got_result, a - b);
      tick();
      check_val("done after pulse", XLEN'(done), '0);
      report_test("timing");
   endtask

   task automatic test_reset();
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      int              done_seen;
      a = next_rand();
      b = next_rand();
      rs1 = a;
      op_b = b;
      op = ALU_OR;
      cmp_mode = CMP_EQ;
      start = 1'b1;
      tick();
      start = 1'b0;
      for (int i = 0; i < 10; i++) begin
         tick();
      end
      rst_n = 1'b0;
      tick();  // sync reset lands on this edge
      check_val("busy in reset", XLEN'(busy), '0);
      check_val("result in reset", result, '0);
      rst_n = 1'b1;
      // the aborted operation must never reach done
      done_seen = 0;
      for (int i = 0; i < XLEN + 2; i++) begin
         if (done !== 1'b0) done_seen++;
         tick();
      end
      check_val("done after aborted op", XLEN'(done_seen), '0);
      run_and_check(ALU_ADD, CMP_LT, a, b);
      report_test("reset");
   endtask

   initial begin
      rst_n = 1'b0;
      start = 1'b0;
      rs1 = '0;
      op_b = '0;
      op = ALU_ADD;
      cmp_mode = CMP_EQ;
      rng_state = 32'h3984;
      errors = 0;
      checks = 0;
      tests = 0;
      base_errors = 0;
      for (int i = 0; i < 10; i++) begin
         tick();
      end
      rst_n = 1'b1;
      tick();

      test_add_sub();
      test_logic();
      test_compare();
      test_slt();
      test_timing();
      test_reset();

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* serial_alu_top.f */
verilog/alu_cfg_pkg.sv
verilog/alu_op_pkg.sv
verilog/operand_serializer.sv
verilog/serial_adder.sv
verilog/serial_alu.sv
verilog/result_deserializer.sv
verilog/serial_alu_top.sv
verif/clk_gen.sv
verif/tb_serial_alu_top.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= serial_alu_top.f
TB_TOP    ?= tb_serial_alu_top
DUT_TOP   ?= serial_alu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(DUT_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TB_TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
